/* rtl/steer_pkg.sv */
package steer_pkg;

  localparam int inst_width = 32;
  localparam int addr_width = 16;

  // opcode field sits in the top bits.
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int opcode_bits = opcode_msb - opcode_lsb + 1;

  // opcode groups, decoded from the top two opcode bits.
  localparam logic [1:0] grp_reg_alu = 2'b00;  // add, sub, cmp, test.
  localparam logic [1:0] grp_imm_alu = 2'b01;  // addi, subi, cmpi, testi.
  localparam logic [1:0] grp_memory  = 2'b10;  // lw, sw, la, sa.
  localparam logic [1:0] grp_jump    = 2'b11;  // jmp, jo, je.

  // compare and test need the flag logic of pipe a.
  localparam logic [opcode_bits-1:0] op_cmp   = 6'b000110;
  localparam logic [opcode_bits-1:0] op_test  = 6'b000111;
  localparam logic [opcode_bits-1:0] op_cmpi  = 6'b010110;
  localparam logic [opcode_bits-1:0] op_testi = 6'b010111;

  localparam int pipe_bits = 2;

  // pipe a is the branch pipe, pipe b the memory pipe.
  localparam logic [pipe_bits-1:0] pipe_dont_care = 2'd0;
  localparam logic [pipe_bits-1:0] pipe_branch    = 2'd1;
  localparam logic [pipe_bits-1:0] pipe_memory    = 2'd2;

  localparam logic [inst_width-1:0] nop_instruction = '0;

  // one issue slot.
  typedef struct packed {
    logic [inst_width-1:0] instr;
    logic [addr_width-1:0] pc;
  } issue_slot_t;

endpackage

/* rtl/pipe_classifier.sv */
module pipe_classifier (
  input  logic [steer_pkg::inst_width-1:0] instr,
  output logic [steer_pkg::pipe_bits-1:0]  pipe_class
);

  import steer_pkg::*;

  logic [opcode_bits-1:0] opcode;
  logic [1:0]             group;

  assign opcode = instr[opcode_msb:opcode_lsb];
  assign group  = opcode[opcode_bits-1 -: 2];

  always_comb begin
    pipe_class = pipe_dont_care;
    case (group)
      grp_reg_alu: begin
        // all-zero falls here too and stays dont care.
        if (opcode == op_cmp || opcode == op_test) begin
          pipe_class = pipe_branch;
        end else begin
          pipe_class = pipe_dont_care;
        end
      end
      grp_imm_alu: begin
        if (opcode == op_cmpi || opcode == op_testi) begin
          pipe_class = pipe_branch;
        end else begin
          pipe_class = pipe_dont_care;
        end
      end
      grp_memory: begin
        pipe_class = pipe_memory;
      end
      grp_jump: begin
        // every jump form resolves in pipe a.
        pipe_class = pipe_branch;
      end
      default: begin
        pipe_class = pipe_dont_care;
      end
    endcase
  end

endmodule

/* rtl/steer.sv */
module steer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             stall,
  input  logic [steer_pkg::inst_width-1:0] instr0,
  input  logic [steer_pkg::inst_width-1:0] instr1,
  input  logic [steer_pkg::addr_width-1:0] pc,
  input  logic [steer_pkg::pipe_bits-1:0]  class0,
  input  logic [steer_pkg::pipe_bits-1:0]  class1,
  output steer_pkg::issue_slot_t           next_a,
  output steer_pkg::issue_slot_t           next_b,
  output logic                             steer_stall,
  output logic                             first
);

  import steer_pkg::*;

  localparam issue_slot_t nop_slot = '{instr: nop_instruction, pc: '0};

  logic [addr_width-1:0] pc_second;  // instr1 address.
  issue_slot_t           slot0;
  issue_slot_t           slot1;
  logic                  prev_split;  // last accepted cycle split its pair.

  assign pc_second = pc + 1'b1;

  assign slot0    = '{instr: instr0, pc: pc};
  assign slot1    = '{instr: instr1, pc: pc_second};

  always_comb begin
    next_a      = slot0;
    next_b      = slot1;
    steer_stall = 1'b0;
    first       = 1'b0;

    case ({class0, class1})
      {pipe_branch, pipe_branch}: begin
        // both need pipe a, one per cycle.
        next_b = nop_slot;
        if (!prev_split) begin
          next_a      = slot0;
          steer_stall = 1'b1;
        end else begin
          next_a = slot1;
        end
        first = 1'b0;
      end
      {pipe_memory, pipe_memory}: begin
        // both need pipe b.
        next_a = nop_slot;
        if (!prev_split) begin
          next_b      = slot0;
          steer_stall = 1'b1;
        end else begin
          next_b = slot1;
        end
        first = 1'b1;
      end
      {pipe_memory, pipe_branch}: begin
        next_a = slot1;
        next_b = slot0;
        first  = 1'b1;
      end
      {pipe_memory, pipe_dont_care}: begin
        next_a = slot1;  // alu op moves to pipe a.
        next_b = slot0;
        first  = 1'b1;
      end
      {pipe_dont_care, pipe_branch}: begin
        next_a = slot1;
        next_b = slot0;
        first  = 1'b1;
      end
      default: begin
        // in order.
        next_a = slot0;
        next_b = slot1;
        first  = 1'b0;
      end
    endcase
  end

  // fetch replays the pair after a split, so the flag picks the second half.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_split <= 1'b0;
    end else if (!stall) begin
      prev_split <= steer_stall;
    end
  end

endmodule

/* rtl/issue_stamp.sv */
module issue_stamp #(
  parameter int ts_width = 60
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                stall,
  input  logic                first,
  output logic [ts_width+3:0] id_a_next,
  output logic [ts_width+3:0] id_b_next
);

  localparam logic [3:0] tag_pos0 = 4'd1;  // came from fetch position 0.
  localparam logic [3:0] tag_pos1 = 4'd2;

  logic [ts_width-1:0] timestamp;
  logic [3:0]          tag_a;
  logic [3:0]          tag_b;

  // accepted cycles since reset, not counting the current one.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timestamp <= '0;
    end else if (!stall) begin
      timestamp <= timestamp + 1'b1;
    end
  end

  // tags let later stages put a swapped pair back in program order.
  assign tag_a = first ? tag_pos1 : tag_pos0;
  assign tag_b = first ? tag_pos0 : tag_pos1;

  assign id_a_next = {timestamp, tag_a};
  assign id_b_next = {timestamp, tag_b};

endmodule

/* rtl/issue_reg.sv */
module issue_reg #(
  parameter int ts_width = 60
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,
  input  steer_pkg::issue_slot_t next_a,
  input  steer_pkg::issue_slot_t next_b,
  input  logic [ts_width+3:0]    id_a_next,
  input  logic [ts_width+3:0]    id_b_next,
  output steer_pkg::issue_slot_t slot_a,
  output steer_pkg::issue_slot_t slot_b,
  output logic [ts_width+3:0]    id_a,
  output logic [ts_width+3:0]    id_b
);

  import steer_pkg::*;

  // empty slot after reset.
  localparam issue_slot_t reset_slot = '{instr: nop_instruction, pc: '0};

  // pipe a side.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_a <= reset_slot;
      id_a   <= '0;
    end else if (!stall) begin
      slot_a <= next_a;
      id_a   <= id_a_next;
    end
  end

  // pipe b side.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_b <= reset_slot;
      id_b   <= '0;
    end else if (!stall) begin
      slot_b <= next_b;
      id_b   <= id_b_next;
    end
  end

endmodule

/* rtl/steer_stage_top.sv */
module steer_stage_top #(
  parameter int ts_width = 60
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [steer_pkg::inst_width-1:0] instr0,
  input  logic [steer_pkg::inst_width-1:0] instr1,
  input  logic [steer_pkg::addr_width-1:0] pc,
  input  logic                             stall,
  output logic                             steer_stall,
  output steer_pkg::issue_slot_t           slot_a,
  output steer_pkg::issue_slot_t           slot_b,
  output logic [ts_width+3:0]              id_a,
  output logic [ts_width+3:0]              id_b
);

  import steer_pkg::*;

  logic [pipe_bits-1:0] class0;
  logic [pipe_bits-1:0] class1;
  issue_slot_t          next_a;
  issue_slot_t          next_b;
  logic                 first;  // pair went out swapped.
  logic [ts_width+3:0]  id_a_next;
  logic [ts_width+3:0]  id_b_next;

  // one classifier per fetch position.
  pipe_classifier cls0 (
    .instr      (instr0),
    .pipe_class (class0)
  );

  pipe_classifier cls1 (
    .instr      (instr1),
    .pipe_class (class1)
  );

  steer u_steer (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .instr0      (instr0),
    .instr1      (instr1),
    .pc          (pc),
    .class0      (class0),
    .class1      (class1),
    .next_a      (next_a),
    .next_b      (next_b),
    .steer_stall (steer_stall),
    .first       (first)
  );

  issue_stamp #(.ts_width(ts_width)) u_issue_stamp (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .first     (first),
    .id_a_next (id_a_next),
    .id_b_next (id_b_next)
  );

  issue_reg #(.ts_width(ts_width)) u_issue_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .next_a    (next_a),
    .next_b    (next_b),
    .id_a_next (id_a_next),
    .id_b_next (id_b_next),
    .slot_a    (slot_a),
    .slot_b    (slot_b),
    .id_a      (id_a),
    .id_b      (id_b)
  );

endmodule

/* tb/steer_checker.sv */
module steer_checker #(
  parameter int ts_width = 60
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,
  input  logic                   steer_stall,
  input  steer_pkg::issue_slot_t slot_a,
  input  steer_pkg::issue_slot_t slot_b,
  input  logic [ts_width+3:0]    id_a,
  input  logic [ts_width+3:0]    id_b,
  input  logic                   test_valid,
  input  logic [127:0]           test_name,
  input  logic                   exp_steer_stall,
  input  steer_pkg::issue_slot_t exp_a,
  input  steer_pkg::issue_slot_t exp_b,
  input  logic [3:0]             exp_tag_a,
  output int                     tests_done,
  output int                     pass_count,
  output int                     fail_count
);

  import steer_pkg::*;

  logic [ts_width-1:0] ts_count;  // accepted cycles seen so far.
  logic                reset_seen;
  logic                pend_valid;
  logic [127:0]        pend_name;
  logic                pend_err;
  issue_slot_t         model_a;
  issue_slot_t         model_b;
  logic [ts_width+3:0] model_id_a;
  logic [ts_width+3:0] model_id_b;

  task automatic compare_field(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %0s %0s expected %h actual %h", pend_name, what, expected, actual);
      pend_err = 1'b1;
    end
  endtask

  task automatic close_test();
    tests_done++;
    if (pend_err) begin
      fail_count++;
    end else begin
      pass_count++;
      $display("ok   %0s", pend_name);
    end
  endtask

  // outputs settle between edges, so everything is sampled on the falling edge.
  always @(negedge clk) begin
    if (!rst_n) begin
      ts_count   = '0;
      reset_seen = 1'b0;
      pend_valid = 1'b0;
      tests_done = 0;
      pass_count = 0;
      fail_count = 0;
    end else begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        pend_name  = "reset";
        pend_err   = 1'b0;
        compare_field("slot_a", 64'(0), 64'(slot_a));
        compare_field("slot_b", 64'(0), 64'(slot_b));
        compare_field("id_a", 64'(0), 64'(id_a));
        compare_field("id_b", 64'(0), 64'(id_b));
        close_test();
      end
      // slots of the line from the previous cycle.
      if (pend_valid) begin
        compare_field("slot_a", 64'(model_a), 64'(slot_a));
        compare_field("slot_b", 64'(model_b), 64'(slot_b));
        compare_field("id_a", 64'(model_id_a), 64'(id_a));
        compare_field("id_b", 64'(model_id_b), 64'(id_b));
        close_test();
        pend_valid = 1'b0;
      end
      if (test_valid) begin
        pend_name = test_name;
        pend_err  = 1'b0;
        compare_field("steer_stall", 64'(exp_steer_stall), 64'(steer_stall));
        if (!stall) begin
          model_a    = exp_a;
          model_b    = exp_b;
          model_id_a = {ts_count, exp_tag_a};
          model_id_b = {ts_count, 4'd3 - exp_tag_a};  // tags 1 and 2 trade places.
        end
        pend_valid = 1'b1;
      end
      if (!stall) begin
        ts_count = ts_count + 1'b1;
      end
    end
  end

endmodule

/* tb/steer_stage_props.sv */
module steer_stage_props #(
  parameter int ts_width = 60
) (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             stall,
  input logic                             steer_stall,
  input logic [steer_pkg::inst_width-1:0] instr0,
  input logic [steer_pkg::inst_width-1:0] instr1,
  input logic [steer_pkg::addr_width-1:0] pc,
  input steer_pkg::issue_slot_t           slot_a,
  input steer_pkg::issue_slot_t           slot_b,
  input logic [ts_width+3:0]              id_a,
  input logic [ts_width+3:0]              id_b
);

  import steer_pkg::*;

  logic a_is_memory;
  logic b_is_branch;
  logic split_taken;

  assign a_is_memory = slot_a.instr[opcode_msb -: 2] == grp_memory;
  assign b_is_branch = (slot_b.instr[opcode_msb -: 2] == grp_jump) ||
                       (slot_b.instr[opcode_msb:opcode_lsb] inside {op_cmp, op_test,
                                                                    op_cmpi, op_testi});
  assign split_taken = steer_stall && !stall;  // split on an accepted cycle.

  no_memory_in_a: assert property (@(posedge clk) disable iff (!rst_n) !a_is_memory)
    else $error("memory-class instruction issued in slot a");

  no_branch_in_b: assert property (@(posedge clk) disable iff (!rst_n) !b_is_branch)
    else $error("branch-class instruction issued in slot b");

  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> ($stable(slot_a) && $stable(slot_b) && $stable(id_a) && $stable(id_b)))
    else $error("issue slots changed while stall was high");

  one_split_per_pair: assert property (@(posedge clk) disable iff (!rst_n)
    split_taken |=> !(split_taken && $stable(instr0) && $stable(instr1) && $stable(pc)))
    else $error("steer_stall high on two accepted cycles for the same pair");

endmodule

bind steer_stage_top steer_stage_props #(.ts_width(ts_width)) props (
  .clk         (clk),
  .rst_n       (rst_n),
  .stall       (stall),
  .steer_stall (steer_stall),
  .instr0      (instr0),
  .instr1      (instr1),
  .pc          (pc),
  .slot_a      (slot_a),
  .slot_b      (slot_b),
  .id_a        (id_a),
  .id_b        (id_b)
);

/* tb/tb_steer_stage.sv */
module tb_steer_stage;

  import steer_pkg::*;

  localparam int ts_width  = 60;
  localparam int max_tests = 64;

  // one line of the test file.
  typedef struct packed {
    logic [127:0]          name;
    logic [inst_width-1:0] instr0;
    logic [inst_width-1:0] instr1;
    logic [addr_width-1:0] pc;
    logic                  stall;
    logic                  steer_stall;
    issue_slot_t           slot_a;
    issue_slot_t           slot_b;
    logic [3:0]            tag_a;
  } test_line_t;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [inst_width-1:0] instr0;
  logic [inst_width-1:0] instr1;
  logic [addr_width-1:0] pc;
  logic                  stall;
  logic                  steer_stall;
  issue_slot_t           slot_a;
  issue_slot_t           slot_b;
  logic [ts_width+3:0]   id_a;
  logic [ts_width+3:0]   id_b;
  test_line_t            cur;         // line in flight, seen by the checker.
  logic                  test_valid;
  int                    tests_done;
  int                    pass_count;
  int                    fail_count;
  test_line_t            tests [max_tests];
  int                    n_tests;
  int                    cycle_count = 0;
  int                    cycle_limit = 0;

  always #10 clk = ~clk;

  steer_stage_top #(.ts_width(ts_width)) UUT (
    .clk(clk), .rst_n(rst_n), .instr0(instr0), .instr1(instr1), .pc(pc),
    .stall(stall), .steer_stall(steer_stall), .slot_a(slot_a), .slot_b(slot_b),
    .id_a(id_a), .id_b(id_b)
  );

  steer_checker #(.ts_width(ts_width)) u_checker (
    .clk(clk), .rst_n(rst_n), .stall(stall), .steer_stall(steer_stall),
    .slot_a(slot_a), .slot_b(slot_b), .id_a(id_a), .id_b(id_b),
    .test_valid(test_valid), .test_name(cur.name), .exp_steer_stall(cur.steer_stall),
    .exp_a(cur.slot_a), .exp_b(cur.slot_b), .exp_tag_a(cur.tag_a),
    .tests_done(tests_done), .pass_count(pass_count), .fail_count(fail_count)
  );

  task automatic load_tests(output int count);
    int                    fd;
    string                 line;
    logic [127:0]          name;
    logic [inst_width-1:0] i0, i1, ai, bi;
    logic [addr_width-1:0] p, ap, bp;
    logic                  st, ss;
    logic [3:0]            tag;
    count = 0;
    fd = $fopen("tb/steer_tests.txt", "r");
    if (fd == 0) begin
      count = -1;
    end else begin
      while (!$feof(fd) && count < max_tests) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#" &&
            $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name, i0, i1, p, st, ss,
                    ai, ap, bi, bp, tag) == 11) begin
          tests[count] = '{name, i0, i1, p, st, ss, '{ai, ap}, '{bi, bp}, tag};
          count++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_line(input test_line_t t, input logic valid);
    instr0     <= t.instr0;
    instr1     <= t.instr1;
    pc         <= t.pc;
    stall      <= t.stall;
    cur        <= t;
    test_valid <= valid;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rst_n      = 1'b0;
    instr0     = '0;
    instr1     = '0;
    pc         = '0;
    stall      = 1'b0;
    cur        = '0;
    test_valid = 1'b0;
    load_tests(n_tests);
    if (n_tests <= 0) begin
      $display("no tests could be read from tb/steer_tests.txt");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      cycle_limit = n_tests + 3 + 10;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int k = 0; k < n_tests; k++) begin
        drive_line(tests[k], 1'b1);
        @(posedge clk);
      end
      drive_line('0, 1'b0);
      while (tests_done < n_tests + 1) @(posedge clk);  // lines plus the reset check.
      $display("tests: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0 && pass_count == n_tests + 1) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

/* tb/steer_tests.txt */
# name instr0 instr1 pc stall steer_stall | next cycle: a_instr a_pc b_instr b_pc tag_a
# all hex; a stall line lists the slots it expects to be held
inorder_dd     04221800 44220005 0100 0 0 04221800 0100 44220005 0101 1
branch_mem     c0000010 80430004 0102 0 0 c0000010 0102 80430004 0103 1
mem_branch     80430004 c4000020 0104 0 0 c4000020 0105 80430004 0104 2
mem_dc         84430008 04221800 0106 0 0 04221800 0107 84430008 0106 2
dc_branch      44220005 c0000010 0108 0 0 c0000010 0109 44220005 0108 2
bb_split_1st   c0000010 c4000020 010a 0 1 c0000010 010a 00000000 0000 1
bb_split_2nd   c0000010 c4000020 010a 0 0 c4000020 010b 00000000 0000 1
mm_split_1st   80430004 84430008 010c 0 1 00000000 0000 80430004 010c 2
mm_split_2nd   80430004 84430008 010c 0 0 00000000 0000 84430008 010d 2
cmp_cmpi_1st   18221000 58220007 010e 0 1 18221000 010e 00000000 0000 1
cmp_cmpi_2nd   18221000 58220007 010e 0 0 58220007 010f 00000000 0000 1
test_testi_1st 1c221000 5c220001 0110 0 1 1c221000 0110 00000000 0000 1
test_testi_2nd 1c221000 5c220001 0110 0 0 5c220001 0111 00000000 0000 1
add_addi       04221800 44220005 0112 0 0 04221800 0112 44220005 0113 1
stall_hold     04221800 80430004 0114 1 0 04221800 0112 44220005 0113 1
stall_release  04221800 80430004 0114 0 0 04221800 0114 80430004 0115 1
split_stall_a  c0000010 18221000 0116 0 1 c0000010 0116 00000000 0000 1
split_stall_b  c0000010 18221000 0116 1 0 c0000010 0116 00000000 0000 1
split_stall_c  c0000010 18221000 0116 1 0 c0000010 0116 00000000 0000 1
split_stall_d  c0000010 18221000 0116 0 0 18221000 0117 00000000 0000 1
after_split    80430004 44220005 0118 0 0 44220005 0119 80430004 0118 2
mm_stalled     80430004 84430008 011a 1 1 44220005 0119 80430004 0118 2
mm_resume      80430004 84430008 011a 0 1 00000000 0000 80430004 011a 2
mm_finish      80430004 84430008 011a 0 0 00000000 0000 84430008 011b 2

/* flist.f */
rtl/steer_pkg.sv
rtl/pipe_classifier.sv
rtl/steer.sv
rtl/issue_stamp.sv
rtl/issue_reg.sv
rtl/steer_stage_top.sv
tb/steer_checker.sv
tb/steer_stage_props.sv
tb/tb_steer_stage.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_steer_stage
FILELIST  = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
